// ==== icache_top.f ====
logic/icache_pkg.sv
logic/sdp_ram.sv
logic/tag_store.sv
logic/icache_ctrl.sv
logic/icache_top.sv
dv/mem_model.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/sdp_ram.sv
  - logic/tag_store.sv
  - logic/icache_ctrl.sv
  - logic/icache_top.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/icache_tb.sv

// ==== dv/icache_tb.sv ====
// ----------------------------------------------------------------------
// Instruction cache testbench
// Table-driven fetches and flushes, response and refill checking
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
;

    localparam int LINES = 16;

    typedef enum {OP_FETCH, OP_FLUSH, OP_IDLE} op_e;
    typedef struct packed {
        op_e   op;
        addr_t addr;
        logic  miss;
    } entry_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     req;
    addr_t    addr;
    logic     flush;
    logic     busy;
    cpu_rsp_t rsp;
    logic     mem_req;
    addr_t    mem_addr;
    mem_rsp_t mem_rsp;

    entry_t tbl[$];
    word_t  exp_q[$];
    addr_t  refill_q[$];
    int     errors = 0;
    int     refills = 0;
    int     exp_misses = 0;
    int     responses = 0;
    int     cyc = 0;
    // Cycle of the last fetch expected to miss
    int     miss_cyc = -100;
    // A fetch sits in the hold register behind a miss
    bit     hold_pend = 1'b0;

    icache_top #(.NUM_LINES(LINES)) DUT (
        .clk(clk), .rst_n(rst_n), .req(req), .addr(addr), .flush(flush),
        .busy(busy), .rsp(rsp), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rsp(mem_rsp)
    );

    mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rsp(mem_rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------------
    // Reference rules and compare tasks
    // ------------------------------------------------------------------
    function automatic addr_t aligned(input addr_t a);
        return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // Memory word is the aligned address and its inverse
    function automatic word_t expected_word(input addr_t a);
        return {aligned(a), ~aligned(a)};
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add(input op_e op, input addr_t a);
        entry_t e;
        e.op   = op;
        e.addr = a;
        e.miss = 1'b0;
        tbl.push_back(e);
    endtask

    // Sequential model of tags and valid bits gives each fetch its miss flag
    task automatic mark_misses();
        logic  vld [LINES];
        addr_t tag [LINES];
        int    idx;
        foreach (vld[i]) vld[i] = 1'b0;
        foreach (tbl[k]) begin
            idx = int'(tbl[k].addr[OFFSET_W +: $clog2(LINES)]);
            if (tbl[k].op == OP_FLUSH) begin
                foreach (vld[i]) vld[i] = 1'b0;
            end else if (tbl[k].op == OP_FETCH) begin
                tbl[k].miss = !(vld[idx] && tag[idx] == (tbl[k].addr >> 7));
                vld[idx] = 1'b1;
                tag[idx] = tbl[k].addr >> 7;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic apply_entry(input entry_t e);
        int x;
        bit ready;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            x = cyc + 1;
            if (!busy && x - miss_cyc > 2) hold_pend = 1'b0;
            case (e.op)
                // Busy rises two cycles after a missing fetch, or a fill cycle frees it early
                OP_FETCH: ready = (x - miss_cyc != 2) &&
                                  (!busy || (mem_rsp.rvalid && !hold_pend));
                OP_FLUSH: ready = (x - miss_cyc > 2) && !busy;
                default:  ready = 1'b1;
            endcase
            if (!ready) begin
                @(posedge clk);
                req   <= 1'b0;
                flush <= 1'b0;
            end
        end
        @(posedge clk);
        req   <= (e.op == OP_FETCH);
        flush <= (e.op == OP_FLUSH);
        addr  <= e.addr;
        if (e.op == OP_FETCH) begin
            exp_q.push_back(expected_word(e.addr));
            if (x - miss_cyc == 1) hold_pend = 1'b1;
            if (e.miss) begin
                refill_q.push_back(aligned(e.addr));
                exp_misses++;
                // Held fetch misses only after its replay, busy is already high
                if (x - miss_cyc != 1) miss_cyc = x;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && rsp.rvalid) begin
            responses++;
            if (exp_q.size() == 0) begin
                $display("Response at %0t with no fetch outstanding", $time);
                errors++;
            end else begin
                check_word(rsp.rdata, exp_q.pop_front(), "response word");
            end
        end
        if (rst_n && mem_req) begin
            refills++;
            if (refill_q.size() == 0) begin
                $display("Refill request at %0t that no miss explains", $time);
                errors++;
            end else begin
                check_addr(mem_addr, refill_q.pop_front(), "refill address");
            end
        end
        // Busy rises two cycles after a fetch that misses
        if (rst_n && cyc == miss_cyc + 2) begin
            check_level(busy, 1'b1, "busy after miss");
        end
        // Fetch and flush go out only in cycles where busy must be low
        if (rst_n && (req || flush)) begin
            check_level(busy, 1'b0, "busy at issue");
        end
    end

    // Watchdog scaled to the table length
    initial begin
        int limit;
        #1;
        limit = tbl.size() * 12 + 40;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        req   = 1'b0;
        addr  = '0;
        flush = 1'b0;
        rst_n = 1'b0;
        // Cold miss, bypass in the fill cycle, then a plain hit
        add(OP_FETCH, 32'h0104);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h0100);
        add(OP_FETCH, 32'h0100);
        // Back-to-back hits on different lines
        add(OP_FETCH, 32'h0208);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h0100);
        add(OP_FETCH, 32'h0208);
        add(OP_FETCH, 32'h0104);
        // Fetches held behind a miss
        add(OP_FETCH, 32'h0300);
        add(OP_FETCH, 32'h0310);
        add(OP_FETCH, 32'h0408);
        add(OP_FETCH, 32'h0100);
        // Same index, different tag
        add(OP_FETCH, 32'h1000);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h1800);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h1000);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h1800);
        // Fetch to the line under fill
        add(OP_FETCH, 32'h2018);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h201c);
        // Flush, then everything misses again
        add(OP_FLUSH, 0);
        add(OP_FETCH, 32'h0100);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h0208);
        add(OP_IDLE, 0);
        add(OP_FETCH, 32'h2018);
        add(OP_FETCH, 32'h2018);
        add(OP_FETCH, 32'h0208);
        mark_misses();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (tbl[k]) apply_entry(tbl[k]);
        @(posedge clk);
        req   <= 1'b0;
        flush <= 1'b0;
        // Drain outstanding responses
        for (int i = 0; i < 100 && (exp_q.size() != 0 || busy); i++) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d fetches never received a response", exp_q.size());
            errors++;
        end
        check_count(refills, exp_misses, "refill count");
        $display("Closing: %0d errors, %0d refills, %0d responses",
                 errors, refills, responses);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== dv/mem_model.sv ====
// ----------------------------------------------------------------------
// Backing memory responder for the instruction cache
// Answers each refill after a random delay, data derived from address
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_model
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mem_req,
    input  addr_t    mem_addr,
    output mem_rsp_t mem_rsp
);

    logic [31:0] rng_state;
    logic        pend;
    int          left;
    addr_t       pend_addr;

    // Xorshift step for the response delay
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Address followed by its inverse
    function automatic word_t word_at(input addr_t a);
        return {a, ~a};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        int d;
        if (!rst_n) begin
            rng_state      <= 32'h7e08;
            pend           <= 1'b0;
            left           <= 0;
            pend_addr      <= '0;
            mem_rsp.rvalid <= 1'b0;
            mem_rsp.rdata  <= '0;
        end else begin
            mem_rsp.rvalid <= 1'b0;
            if (mem_req) begin
                // Delay of 1 to 6 cycles after the request
                d = int'(xorshift(rng_state) % 6) + 1;
                rng_state <= xorshift(rng_state);
                if (d == 1) begin
                    mem_rsp.rvalid <= 1'b1;
                    mem_rsp.rdata  <= word_at(mem_addr);
                end else begin
                    pend      <= 1'b1;
                    left      <= d - 1;
                    pend_addr <= mem_addr;
                end
            end else if (pend) begin
                if (left == 1) begin
                    mem_rsp.rvalid <= 1'b1;
                    mem_rsp.rdata  <= word_at(pend_addr);
                    pend           <= 1'b0;
                end else begin
                    left <= left - 1;
                end
            end
        end
    end

endmodule

// ==== logic/icache_top.sv ====
// ----------------------------------------------------------------------
// Direct-mapped read-only instruction cache
// Controller, tag store and data RAM
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int NUM_LINES = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  addr_t    addr,
    input  logic     flush,
    output logic     busy,
    output cpu_rsp_t rsp,
    output logic     mem_req,
    output addr_t    mem_addr,
    input  mem_rsp_t mem_rsp
);

    localparam int IDX_W = $clog2(NUM_LINES);

    // Lookup path
    logic  rd_en;
    addr_t rd_addr;
    logic  hit;
    word_t rd_word;

    // Refill write path
    logic  fill;
    addr_t fill_addr;
    word_t fill_data;

    // ------------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------------
    icache_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .addr      (addr),
        .busy      (busy),
        .rsp       (rsp),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_rsp   (mem_rsp),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .hit       (hit),
        .rd_word   (rd_word),
        .fill      (fill),
        .fill_addr (fill_addr),
        .fill_data (fill_data)
    );

    // ------------------------------------------------------------------
    // Tags and valid bits
    // ------------------------------------------------------------------
    tag_store #(
        .NUM_LINES (NUM_LINES)
    ) u_tag_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .fill      (fill),
        .fill_addr (fill_addr),
        .hit       (hit)
    );

    // ------------------------------------------------------------------
    // Data array, one word per line
    // ------------------------------------------------------------------
    sdp_ram #(
        .DEPTH (NUM_LINES),
        .WIDTH (WORD_W)
    ) u_data_ram (
        .clk   (clk),
        .we    (fill),
        .waddr (fill_addr[OFFSET_W +: IDX_W]),
        .wdata (fill_data),
        .raddr (rd_addr[OFFSET_W +: IDX_W]),
        .rdata (rd_word)
    );

    // Flush is a CPU-side op and never rides on a fetch
    a_flush_not_req: assert property (
        @(posedge clk) disable iff (!rst_n) !(flush && req)
    ) else $error("flush together with fetch request");

endmodule

// ==== logic/icache_ctrl.sv ====
// ----------------------------------------------------------------------
// Instruction cache controller
// Lookup stage, miss and refill FSM, replay of the held request
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int NUM_LINES = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  addr_t    addr,
    output logic     busy,
    output cpu_rsp_t rsp,
    output logic     mem_req,
    output addr_t    mem_addr,
    input  mem_rsp_t mem_rsp,
    output logic     rd_en,
    output addr_t    rd_addr,
    input  logic     hit,
    input  word_t    rd_word,
    output logic     fill,
    output addr_t    fill_addr,
    output word_t    fill_data
);

    // Line count must split cleanly into index bits
    if ((NUM_LINES < 2) || ((NUM_LINES & (NUM_LINES - 1)) != 0)) begin : g_bad_lines
        $error("NUM_LINES must be a power of two, at least 2");
    end

    ctrl_state_e state;
    ctrl_state_e state_n;

    // Lookup stage
    logic  lk_valid;
    addr_t lk_addr;
    // Request accepted behind a miss
    logic  hold_valid;
    addr_t hold_addr;
    // Line being refilled and its returned word
    addr_t miss_addr;
    word_t fill_word;

    logic  acc;
    logic  replay;
    logic  lk_hit;
    logic  lk_miss;
    logic  busy_n;

    // ------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------
    assign acc     = req && !busy;
    assign replay  = (state == ST_REPLAY);
    assign lk_hit  = lk_valid && hit;
    assign lk_miss = lk_valid && !hit;

    // Read index to tag and data RAM
    assign rd_en   = acc || replay;
    assign rd_addr = replay ? hold_addr : addr;

    // A miss discards the lookup behind it, that one goes to hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_valid   <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            lk_valid <= rd_en && !lk_miss;
            if (lk_miss && acc) begin
                hold_valid <= 1'b1;
            end else if (replay) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // Address payload
    always_ff @(posedge clk) begin
        if (rd_en) begin
            lk_addr <= rd_addr;
        end
        if (lk_miss && acc) begin
            hold_addr <= addr;
        end
        if (lk_miss) begin
            miss_addr <= lk_addr;
        end
        if (mem_rsp.rvalid) begin
            fill_word <= mem_rsp.rdata;
        end
    end

    // ------------------------------------------------------------------
    // Refill FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_n = state;
        case (state)
            ST_RUN:    if (lk_miss) state_n = ST_REQ;
            ST_REQ:    state_n = ST_WAIT;
            ST_WAIT:   if (mem_rsp.rvalid) state_n = ST_FILL;
            ST_FILL:   state_n = hold_valid ? ST_REPLAY : ST_RUN;
            ST_REPLAY: state_n = ST_RUN;
            default:   state_n = ST_RUN;
        endcase
    end

    // Busy drops in the fill cycle when nothing is held,
    // otherwise after the replayed lookup resolves
    always_comb begin
        case (state_n)
            ST_RUN:  busy_n = replay;
            ST_FILL: busy_n = hold_valid;
            default: busy_n = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_RUN;
            busy  <= 1'b0;
        end else begin
            state <= state_n;
            busy  <= busy_n;
        end
    end

    // ------------------------------------------------------------------
    // Memory side and RAM write port
    // ------------------------------------------------------------------
    assign mem_req   = (state == ST_REQ);
    // Word-aligned refill address
    assign mem_addr  = {miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign fill      = (state == ST_FILL);
    assign fill_addr = miss_addr;
    assign fill_data = fill_word;

    // ------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------
    // Hit and fill answers never share a cycle
    always_comb begin
        rsp.rvalid = lk_hit || fill;
        rsp.rdata  = fill ? fill_word : rd_word;
    end

    // CPU must honor busy
    a_no_req_busy: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> !req
    ) else $error("fetch request while busy");

    // Memory answers only the refill that is outstanding
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) mem_rsp.rvalid |-> (state == ST_WAIT)
    ) else $error("memory response outside refill wait");

endmodule

// ==== logic/tag_store.sv ====
// ----------------------------------------------------------------------
// Tag store, tag RAM plus valid bits
// Produces the registered hit for the lookup stage
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tag_store
    import icache_pkg::*;
#(
    parameter int NUM_LINES = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  rd_en,
    input  addr_t rd_addr,
    input  logic  fill,
    input  addr_t fill_addr,
    output logic  hit
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // ------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------
    idx_t rd_idx;
    tag_t rd_tag;
    idx_t fill_idx;
    tag_t fill_tag;

    assign rd_idx   = rd_addr[OFFSET_W +: IDX_W];
    assign rd_tag   = rd_addr[ADDR_W-1 -: TAG_W];
    assign fill_idx = fill_addr[OFFSET_W +: IDX_W];
    assign fill_tag = fill_addr[ADDR_W-1 -: TAG_W];

    // ------------------------------------------------------------------
    // Tag RAM
    // ------------------------------------------------------------------
    tag_t tag_rd;

    sdp_ram #(
        .DEPTH (NUM_LINES),
        .WIDTH (TAG_W)
    ) u_tag_ram (
        .clk   (clk),
        .we    (fill),
        .waddr (fill_idx),
        .wdata (fill_tag),
        .raddr (rd_idx),
        .rdata (tag_rd)
    );

    // ------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------
    logic [NUM_LINES-1:0] valid;

    // Flush clears all lines, a fill on the same line still sets it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end
            if (fill) begin
                valid[fill_idx] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Lookup registers
    // ------------------------------------------------------------------
    logic rd_en_q;
    logic valid_q;
    tag_t rd_tag_q;

    // Valid bit read follows the same write-first rule as the RAM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            if (fill && (fill_idx == rd_idx)) begin
                valid_q <= 1'b1;
            end else if (flush) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= valid[rd_idx];
            end
        end
    end

    // Tag under lookup, compared against the RAM output next cycle
    always_ff @(posedge clk) begin
        rd_tag_q <= rd_tag;
    end

    assign hit = rd_en_q && valid_q && (tag_rd == rd_tag_q);

    // Flush comes from the CPU side and fill from the refill FSM
    a_no_flush_on_fill: assert property (
        @(posedge clk) disable iff (!rst_n) !(flush && fill)
    ) else $error("flush and fill in the same cycle");

endmodule

// ==== logic/sdp_ram.sv ====
// ----------------------------------------------------------------------
// Simple dual-port RAM, one write and one read port
// One-cycle read, a same-cycle write to the read address wins
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sdp_ram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    typedef logic [WIDTH-1:0] ram_word_t;

    // Storage array, contents undefined until written
    ram_word_t mem [DEPTH];

    // Array read register
    ram_word_t rd_q;
    // Collision flag and the write word it selects
    logic      coll_q;
    ram_word_t wdata_q;

    logic      coll;

    // Read and write hit the same entry in this cycle
    assign coll = we && (raddr == waddr);

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, array value before this cycle's write
    always_ff @(posedge clk) begin
        rd_q    <= mem[raddr];
        coll_q  <= coll;
        wdata_q <= wdata;
    end

    // Bypass mux gives write-first behavior
    assign rdata = coll_q ? wdata_q : rd_q;

    // Unknown write address would corrupt an arbitrary entry
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("sdp_ram write with unknown address");

endmodule

// ==== logic/icache_pkg.sv ====
// ----------------------------------------------------------------------
// Instruction cache shared definitions
// Widths, fetch and refill response structs, controller states
// ----------------------------------------------------------------------
package icache_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    // Byte address
    localparam int ADDR_W   = 32;
    // One instruction word per line
    localparam int WORD_W   = 64;
    // Byte offset inside a word
    localparam int OFFSET_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // ------------------------------------------------------------------
    // Responses
    // ------------------------------------------------------------------
    // Refill return from backing memory
    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } mem_rsp_t;

    // Fetch answer toward the CPU
    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } cpu_rsp_t;

    // ------------------------------------------------------------------
    // Controller FSM
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_RUN,
        ST_REQ,
        ST_WAIT,
        ST_FILL,
        ST_REPLAY
    } ctrl_state_e;

endpackage
